// ==== bench/instr_patterns.txt ====
# test hi lo display: test number in decimal, then high byte, low byte
# and the expected display word after the instruction, all in hex
1 10 73 0007
1 10 93 0010
2 43 03 A301
3 01 33 4602
3 10 F1 4602
3 00 12 4602
3 01 12 4602
3 05 23 461C
3 00 13 000F
3 01 23 002D
3 05 33 0000
4 10 54 0000
4 00 25 0000
4 10 F6 0000
4 42 04 0000
4 42 05 0000
4 42 06 0000
4 43 03 000F
4 43 03 001E
4 43 03 0005
5 02 13 0005
5 3F 23 0005
5 40 13 0005
5 80 13 0005
5 C1 23 0005
5 90 F3 0005

// ==== compile.f ====
+incdir+src
src/stack_cpu_pkg.sv
src/uart_byte_rx.sv
src/stack_fill.sv
src/mem_arbiter.sv
src/word_ram.sv
src/instr_exec.sv
src/uart_stack_top.sv
bench/tb_uart_stack.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_uart_stack -f compile.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_uart_stack > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Testbench reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "No result in log"; exit 1; }
echo "Simulation passed"

// ==== bench/tb_uart_stack.sv ====
`timescale 1ns/10ps

module tb_uart_stack;

    // Serial bit time in clock cycles for 8N1 framing
    localparam int bit_cycles = 16;
    // Settle time after the last byte of an instruction
    localparam int settle_cycles = 40;
    localparam int test_total = 6;

    // Own copies of the high-byte encodings for generated stimulus
    localparam logic [7:0] hi_mov  = 8'h00;
    localparam logic [7:0] hi_xor  = 8'h05;
    localparam logic [7:0] hi_addi = 8'h10;

    logic        clk_100mhz = 1'b0;
    logic        rst_n      = 1'b0;
    logic        uart_rx    = 1'b1;
    logic [15:0] display_word;

    // Random source and register file model
    logic [15:0] lfsr_state = 16'd42182;
    logic [15:0] model_regs [16];

    int    error_count     = 0;
    int    check_count     = 0;
    int    tests_run       = 0;
    int    tests_failed    = 0;
    string test_names [1:test_total];

    uart_stack_top dut_i (
        .clk_100mhz   (clk_100mhz),
        .rst_n        (rst_n),
        .uart_rx      (uart_rx),
        .display_word (display_word)
    );

    // 10 ns clock
    always #5 clk_100mhz = ~clk_100mhz;

    task automatic compare_word(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk_100mhz);
        end
    endtask

    // Start bit, data LSB first and one stop bit
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk_100mhz);
            uart_rx <= frame[b];
            wait_cycles(bit_cycles - 1);
        end
    endtask

    // High byte first, then settle and park on a falling edge for sampling
    task automatic send_instr(input logic [7:0] hi_byte, input logic [7:0] lo_byte);
        send_byte(hi_byte);
        send_byte(lo_byte);
        wait_cycles(settle_cycles);
        @(negedge clk_100mhz);
    endtask

    // Galois form with taps 0xB400
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int count, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic report_test(input int id, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", id, test_names[id]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id, test_names[id],
                     error_count - errors_before);
        end
    endtask

    // Lines hold test number, high byte, low byte and expected display word
    task automatic run_pattern_file(output logic [15:0] last_display);
        int          fd;
        int          fields;
        int          test_id;
        int          current_id;
        int          errors_before;
        logic [7:0]  hi_byte;
        logic [7:0]  lo_byte;
        logic [15:0] expected;
        string       line;
        current_id    = 0;
        errors_before = error_count;
        last_display  = 16'h0000;
        // Display reset value belongs to the first test
        compare_word("display_word", 16'h0000, display_word);
        fd = $fopen("bench/instr_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/instr_patterns.txt for reading");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%d %h %h %h", test_id, hi_byte, lo_byte, expected);
            // Comments and blank lines give fewer fields
            if (fields == 4) begin
                if (test_id != current_id) begin
                    if (current_id != 0) begin
                        report_test(current_id, errors_before);
                        errors_before = error_count;
                    end
                    current_id = test_id;
                end
                send_instr(hi_byte, lo_byte);
                compare_word("display_word", expected, display_word);
                last_display = expected;
            end
        end
        $fclose(fd);
        if (current_id != 0) begin
            report_test(current_id, errors_before);
        end else begin
            $display("No instruction lines found in bench/instr_patterns.txt");
            error_count++;
        end
    endtask

    // ADDI and XOR on r8 to r11 with each result copied into r3
    task automatic run_random(input logic [15:0] display_start, input int steps);
        int          errors_before;
        logic [15:0] op_bit;
        logic [15:0] dst;
        logic [15:0] src;
        logic [15:0] imm;
        errors_before = error_count;
        model_regs[3] = display_start;
        // XOR with itself clears the working registers
        for (int r = 8; r < 12; r++) begin
            model_regs[r] = '0;
            send_instr(hi_xor, {4'(r), 4'(r)});
            compare_word("display_word", model_regs[3], display_word);
        end
        for (int s = 0; s < steps; s++) begin
            draw_bits(1, op_bit);
            draw_bits(2, dst);
            dst = dst + 16'd8;
            if (op_bit[0]) begin
                draw_bits(4, imm);
                model_regs[dst[3:0]] = model_regs[dst[3:0]] + imm;
                send_instr(hi_addi, {imm[3:0], dst[3:0]});
            end else begin
                draw_bits(2, src);
                src = src + 16'd8;
                model_regs[dst[3:0]] = model_regs[dst[3:0]] ^ model_regs[src[3:0]];
                send_instr(hi_xor, {src[3:0], dst[3:0]});
            end
            // r3 untouched so far
            compare_word("display_word", model_regs[3], display_word);
            model_regs[3] = model_regs[dst[3:0]];
            send_instr(hi_mov, {dst[3:0], 4'd3});
            compare_word("display_word", model_regs[3], display_word);
        end
        report_test(6, errors_before);
    endtask

    initial begin
        logic [15:0] last_display;
        test_names[1] = "addi_after_reset";
        test_names[2] = "pop_before_push";
        test_names[3] = "mov_add_xor";
        test_names[4] = "push_pop_order";
        test_names[5] = "ignored_instr";
        test_names[6] = "random_addi_xor";
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = '0;
        end
        // Reset held for 8 cycles
        wait_cycles(8);
        rst_n <= 1'b1;
        @(negedge clk_100mhz);
        run_pattern_file(last_display);
        run_random(last_display, 12);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== src/uart_stack_top.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module uart_stack_top import stack_cpu_pkg::*; (
    input  logic  clk_100mhz,
    input  logic  rst_n,
    input  logic  uart_rx,
    output word_t display_word
);

    // UART byte link
    logic [7:0] rx_byte;
    logic       rx_valid;

    // Filler port
    logic       fill_req;
    mem_req_t   fill_cmd;
    logic       fill_done;

    // Executor port
    logic       exec_req;
    mem_req_t   exec_cmd;
    logic       exec_done;
    word_t      exec_rdata;

    // Arbiter to RAM
    logic       ram_req;
    mem_req_t   ram_cmd;
    logic       ram_done;
    word_t      ram_rdata;

    uart_byte_rx #(
        .clks_per_bit(`UART_CLKS_PER_BIT)
    ) rx_i (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .rx_line    (uart_rx),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid)
    );

    stack_fill fill_i (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .req        (fill_req),
        .cmd        (fill_cmd),
        .done       (fill_done)
    );

    mem_arbiter arb_i (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .fill_req   (fill_req),
        .fill_cmd   (fill_cmd),
        .fill_done  (fill_done),
        .exec_req   (exec_req),
        .exec_cmd   (exec_cmd),
        .exec_done  (exec_done),
        .exec_rdata (exec_rdata),
        .ram_req    (ram_req),
        .ram_cmd    (ram_cmd),
        .ram_done   (ram_done),
        .ram_rdata  (ram_rdata)
    );

    word_ram ram_i (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .req        (ram_req),
        .cmd        (ram_cmd),
        .done       (ram_done),
        .rdata      (ram_rdata)
    );

    instr_exec exec_i (
        .clk_100mhz   (clk_100mhz),
        .rst_n        (rst_n),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .req          (exec_req),
        .cmd          (exec_cmd),
        .done         (exec_done),
        .rdata        (exec_rdata),
        .display_word (display_word)
    );

endmodule

// ==== src/instr_exec.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module instr_exec import stack_cpu_pkg::*; (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic       req,
    output mem_req_t   cmd,
    input  logic       done,
    input  word_t      rdata,
    output word_t      display_word
);

    // Opcode families
    localparam logic [1:0] op_alu = 2'd0;
    localparam logic [1:0] op_mem = 2'd1;

    // ALU mods
    localparam logic [5:0] mod_mov  = 6'd0;
    localparam logic [5:0] mod_add  = 6'd1;
    localparam logic [5:0] mod_xor  = 6'd5;
    localparam logic [5:0] mod_addi = 6'd16;

    // Stack mods
    localparam logic [5:0] mod_push = 6'd2;
    localparam logic [5:0] mod_pop  = 6'd3;

    exec_state_t state;
    word_t       regs [16];
    addr_t       sp;
    addr_t       sp_dec;
    logic [7:0]  hi_byte;
    logic        byte_pending;
    reg_idx_t    pop_dst;
    instr_t      instr;

    // Second byte completes the word, high byte came first
    assign instr  = instr_t'({hi_byte, rx_byte});
    assign sp_dec = sp - 24'd2;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state        <= FETCH;
            sp           <= `SP_RESET;
            hi_byte      <= '0;
            byte_pending <= 1'b0;
            pop_dst      <= '0;
            req          <= 1'b0;
            cmd          <= '0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= `REG_RESET;
            end
        end else begin
            case (state)
                FETCH: begin
                    // Bytes outside FETCH are dropped
                    if (rx_valid && !byte_pending) begin
                        hi_byte      <= rx_byte;
                        byte_pending <= 1'b1;
                    end else if (rx_valid) begin
                        byte_pending <= 1'b0;
                        case (instr.opcode)
                            op_alu: begin
                                case (instr.mod)
                                    mod_mov:  regs[instr.dst] <= regs[instr.src];
                                    mod_add:  regs[instr.dst] <= regs[instr.dst] + regs[instr.src];
                                    mod_xor:  regs[instr.dst] <= regs[instr.dst] ^ regs[instr.src];
                                    // Immediate is the src field, zero-extended
                                    mod_addi: regs[instr.dst] <= regs[instr.dst]
                                                                 + word_t'(instr.src);
                                    default: ;
                                endcase
                            end
                            op_mem: begin
                                case (instr.mod)
                                    mod_push: begin
                                        // Write at sp, then step up
                                        cmd   <= '{we: 1'b1, addr: sp, wdata: regs[instr.dst]};
                                        req   <= 1'b1;
                                        sp    <= sp + 24'd2;
                                        state <= PUSH_WAIT;
                                    end
                                    mod_pop: begin
                                        // Step down, then read the new top
                                        cmd     <= '{we: 1'b0, addr: sp_dec, wdata: '0};
                                        req     <= 1'b1;
                                        sp      <= sp_dec;
                                        pop_dst <= instr.dst;
                                        state   <= POP_WAIT;
                                    end
                                    default: ;
                                endcase
                            end
                            // Opcodes 2 and 3 unused
                            default: ;
                        endcase
                    end
                end
                PUSH_WAIT: begin
                    if (done) begin
                        req   <= 1'b0;
                        state <= FETCH;
                    end
                end
                POP_WAIT: begin
                    // rdata valid with done
                    if (done) begin
                        regs[pop_dst] <= rdata;
                        req           <= 1'b0;
                        state         <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    // r3 drives the display, one cycle behind
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            display_word <= `REG_RESET;
        end else begin
            display_word <= regs[3];
        end
    end

endmodule

// ==== src/word_ram.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module word_ram import stack_cpu_pkg::*; (
    input  logic     clk_100mhz,
    input  logic     rst_n,
    input  logic     req,
    input  mem_req_t cmd,
    output logic     done,
    output word_t    rdata
);

    localparam int idx_w = $clog2(`RAM_DEPTH_WORDS);

    word_t            mem [`RAM_DEPTH_WORDS];
    logic [idx_w-1:0] word_idx;
    logic             access;

    // Byte address to word index, upper bits ignored
    assign word_idx = cmd.addr[idx_w:1];

    // One access per request, req may linger a cycle after done
    assign access = req && !done;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= access;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (access) begin
            if (cmd.we) begin
                mem[word_idx] <= cmd.wdata;
            end
            // Read data lines up with done
            rdata <= mem[word_idx];
        end
    end

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/10ps

module mem_arbiter import stack_cpu_pkg::*; (
    input  logic     clk_100mhz,
    input  logic     rst_n,
    // Boot filler, highest priority
    input  logic     fill_req,
    input  mem_req_t fill_cmd,
    output logic     fill_done,
    // Executor
    input  logic     exec_req,
    input  mem_req_t exec_cmd,
    output logic     exec_done,
    output word_t    exec_rdata,
    // Toward the RAM
    output logic     ram_req,
    output mem_req_t ram_cmd,
    input  logic     ram_done,
    input  word_t    ram_rdata
);

    // RAM locked to one owner until its done
    logic busy;
    // Owner select, set for executor
    logic owner_exec;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            owner_exec <= 1'b0;
            ram_req    <= 1'b0;
            ram_cmd    <= '0;
        end else begin
            if (!busy) begin
                // Fixed priority, filler first
                if (fill_req) begin
                    busy       <= 1'b1;
                    owner_exec <= 1'b0;
                    ram_req    <= 1'b1;
                    ram_cmd    <= fill_cmd;
                end else if (exec_req) begin
                    busy       <= 1'b1;
                    owner_exec <= 1'b1;
                    ram_req    <= 1'b1;
                    ram_cmd    <= exec_cmd;
                end
            end else if (ram_done) begin
                // Release the lock
                busy    <= 1'b0;
                ram_req <= 1'b0;
            end
        end
    end

    // Done and read data go back to the owner only
    assign fill_done  = ram_done && busy && !owner_exec;
    assign exec_done  = ram_done && busy && owner_exec;
    assign exec_rdata = (busy && owner_exec) ? ram_rdata : '0;

endmodule

// ==== src/stack_fill.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module stack_fill import stack_cpu_pkg::*; (
    input  logic     clk_100mhz,
    input  logic     rst_n,
    output logic     req,
    output mem_req_t cmd,
    input  logic     done
);

    localparam int idx_w = $clog2(`FILL_WORDS);
    localparam logic [idx_w-1:0] idx_last = idx_w'(`FILL_WORDS - 1);

    fill_state_t      state;
    logic [idx_w-1:0] word_idx;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FILL_ISSUE;
            word_idx <= '0;
            req      <= 1'b0;
            cmd      <= '0;
        end else begin
            case (state)
                FILL_ISSUE: begin
                    // Word address stepped by two bytes
                    cmd <= '{we: 1'b1,
                             addr: `STACK_BASE + addr_t'({word_idx, 1'b0}),
                             wdata: `FILL_PATTERN};
                    req   <= 1'b1;
                    state <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    // Drop req right after done
                    if (done) begin
                        req      <= 1'b0;
                        word_idx <= word_idx + 1'b1;
                        state    <= (word_idx == idx_last) ? FILL_DONE : FILL_ISSUE;
                    end
                end
                FILL_DONE: begin
                    // Idle until next reset
                    req <= 1'b0;
                end
                default: state <= FILL_DONE;
            endcase
        end
    end

endmodule

// ==== src/uart_byte_rx.sv ====
`timescale 1ns/10ps

module uart_byte_rx #(
    // Default is 115200 baud at 100 MHz
    parameter int clks_per_bit = 868
) (
    input  logic       clk_100mhz,
    input  logic       rst_n,
    input  logic       rx_line,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    localparam int cnt_w = $clog2(clks_per_bit);
    // Last count of a full bit time
    localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);
    // Middle of the start bit
    localparam logic [cnt_w-1:0] bit_half = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;

    // Two-stage synchronizer, line idles high
    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_line;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            shift_reg <= '0;
            rx_byte   <= '0;
            rx_valid  <= 1'b0;
        end else begin
            // Strobe lasts one cycle
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (clk_cnt == bit_half) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch check at mid start bit
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        // LSB first
                        shift_reg <= {rx_sync, shift_reg[7:1]};
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == bit_last) begin
                        clk_cnt <= '0;
                        state   <= RX_IDLE;
                        // Low stop bit means framing error, drop the byte
                        if (rx_sync) begin
                            rx_byte  <= shift_reg;
                            rx_valid <= 1'b1;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== src/stack_cpu_pkg.sv ====
package stack_cpu_pkg;

    // 16-bit data word
    typedef logic [15:0] word_t;

    // 24-bit byte address, words sit on even addresses
    typedef logic [23:0] addr_t;

    // Register file index
    typedef logic [3:0] reg_idx_t;

    // Instruction layout, high byte first on the wire
    // [15:14] opcode, [13:8] mod, [7:4] src, [3:0] dst
    typedef struct packed {
        logic [1:0] opcode;
        logic [5:0] mod;
        reg_idx_t   src;
        reg_idx_t   dst;
    } instr_t;

    // One memory request, held stable until done
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // Executor FSM
    typedef enum logic [1:0] {
        FETCH,
        PUSH_WAIT,
        POP_WAIT
    } exec_state_t;

    // Boot filler FSM
    typedef enum logic [1:0] {
        FILL_ISSUE,
        FILL_WAIT,
        FILL_DONE
    } fill_state_t;

endpackage

// ==== src/stack_cpu_defs.svh ====
`ifndef STACK_CPU_DEFS_SVH
`define STACK_CPU_DEFS_SVH

// Clock cycles per serial bit
// 16 for simulation, 868 for 115200 baud at 100 MHz
`define UART_CLKS_PER_BIT 16

// Byte address where the pattern area starts
`define STACK_BASE 24'h900000

// Number of pattern words written after reset
`define FILL_WORDS 32

// Pattern word for the stack region
`define FILL_PATTERN 16'hA301

// Stack pointer starts just past the pattern area
`define SP_RESET (`STACK_BASE + 24'(2 * `FILL_WORDS))

// On-chip RAM size in words
// Indexed from byte address bit 1 upward, wraps outside the region
`define RAM_DEPTH_WORDS 64

// Register file and display word after reset
`define REG_RESET 16'h0000

`endif
